/* src.f */
verilog/xgmii_pkg.sv
verilog/async_word_fifo.sv
verilog/xgmii_frame_gen.sv
verilog/xgmii_sink.sv
verilog/xgmii_loopback_top.sv
tb/xgmii_check_monitor.sv
tb/tb_xgmii_loopback.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_xgmii_loopback -f src.f \
	&& out="$(./obj_dir/Vtb_xgmii_loopback)" \
	&& printf '%s\n' "$out" \
	&& printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" \
	|| { echo "simulation did not pass"; exit 1; }

/* tb/tb_xgmii_loopback.sv */
// testbench for the XGMII loopback checker, runs a table of frame and corruption scenarios
`default_nettype none

module tb_xgmii_loopback;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int payload_words = xgmii_pkg::default_payload_words;
	localparam int gap_words     = xgmii_pkg::default_gap_words;
	localparam int num_rows      = 5;
	localparam int max_delay     = 12;
	localparam int wait_limit    = 4000;
	// the loop path has a fixed latency of its own ahead of the per test delay
	// a start word thus never comes back before its stored copy has crossed the FIFO
	localparam int path_latency  = 3;

	// columns are frames, corrupted payload words and loopback delay, a delay of 0 means random
	int row_frames[num_rows]  = '{20, 5, 15, 12, 11};
	int row_corrupt[num_rows] = '{0, 0, 3, 2, 0};
	int row_delay[num_rows]   = '{3, 0, 0, 0, 12};

	logic xgmii_tx_clk;
	logic xgmii_rx_clk;
	logic rx_ready;
	logic gen_enable;
	logic test_done;
	logic check_reset;
	logic check_verdict;

	xgmii_pkg::xgmii_word_t  xgmii_rx;
	xgmii_pkg::xgmii_word_t  xgmii_tx;
	xgmii_pkg::sink_status_t status;
	xgmii_pkg::xgmii_word_t  loop_pipe[max_delay + path_latency];

	int          delay = 1;
	int          test_id = 0;
	int          frame_target = 0;
	int          test_corrupt = 0;
	int          injected = 0;
	int          payload_idx = 0;
	int          timeouts = 0;
	logic [31:0] rng_state = 32'd20843;

	xgmii_loopback_top u_dut (
		.xgmii_tx_clk (xgmii_tx_clk),
		.xgmii_rx_clk (xgmii_rx_clk),
		.rx_ready     (rx_ready),
		.gen_enable   (gen_enable),
		.test_done    (test_done),
		.xgmii_rx     (xgmii_rx),
		.xgmii_tx     (xgmii_tx),
		.status       (status)
	);

	xgmii_check_monitor u_mon (
		.xgmii_tx_clk  (xgmii_tx_clk),
		.xgmii_rx_clk  (xgmii_rx_clk),
		.rx_ready      (rx_ready),
		.xgmii_tx      (xgmii_tx),
		.status        (status),
		.test_id       (test_id),
		.frame_target  (frame_target),
		.corrupt_count (test_corrupt),
		.check_reset   (check_reset),
		.check_verdict (check_verdict)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	initial begin
		xgmii_tx_clk = 1'b0;
		forever #10 xgmii_tx_clk = ~xgmii_tx_clk;
	end

	initial begin
		xgmii_rx_clk = 1'b0;
		#7;
		forever #10 xgmii_rx_clk = ~xgmii_rx_clk;
	end

	// delayed copy of the transmit bus, sampled on the rising and driven on the falling rx edge
	initial begin
		int i;
		logic [31:0] r;
		xgmii_pkg::xgmii_word_t w;
		xgmii_rx.flat = {{8{xgmii_pkg::xgmii_idle}}, 8'hff};
		for (i = 0; i < max_delay + path_latency; i++) begin
			loop_pipe[i] = xgmii_rx;
		end
		forever begin
			@(posedge xgmii_rx_clk);
			for (i = max_delay + path_latency - 1; i > 0; i--) begin
				loop_pipe[i] = loop_pipe[i - 1];
			end
			loop_pipe[0] = xgmii_tx;
			@(negedge xgmii_rx_clk);
			w = loop_pipe[path_latency + delay - 1];
			if (!rx_ready) begin
				injected    = 0;
				payload_idx = 0;
			end else if (w.lanes.c == 8'h00) begin
				// payload words are the only ones with no control bit set
				if ((injected < test_corrupt) && (payload_idx % 5 == 2)) begin
					next_random(r);
					w.lanes.d[r[5:0]] = ~w.lanes.d[r[5:0]];
					injected = injected + 1;
				end
				payload_idx = payload_idx + 1;
			end
			xgmii_rx = w;
		end
	end

	task automatic apply_reset();
		@(negedge xgmii_tx_clk);
		rx_ready   = 1'b0;
		gen_enable = 1'b0;
		test_done  = 1'b0;
		repeat (16) @(negedge xgmii_tx_clk);
		rx_ready = 1'b1;
		@(negedge xgmii_rx_clk);
		check_reset = 1'b1;
		@(negedge xgmii_rx_clk);
		check_reset = 1'b0;
	endtask

	task automatic send_frames(input int frames);
		int n;
		n = 0;
		@(negedge xgmii_tx_clk);
		gen_enable = 1'b1;
		while ((u_mon.frames_seen < frames) && (n < wait_limit)) begin
			@(negedge xgmii_tx_clk);
			n = n + 1;
		end
		gen_enable = 1'b0;
		if (n >= wait_limit) begin
			$display("test %0d: the generator did not send %0d frames in time", test_id, frames);
			timeouts = timeouts + 1;
		end
	endtask

	task automatic wait_drained();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while ((quiet < gap_words + delay + payload_words + 2) && (n < wait_limit)) begin
			@(posedge xgmii_rx_clk);
			if (status.idle_state && status.fifo_empty && !xgmii_pkg::is_start(xgmii_rx)) begin
				quiet = quiet + 1;
			end else begin
				quiet = 0;
			end
			n = n + 1;
		end
		if (n >= wait_limit) begin
			$display("test %0d: the receive side never went idle with an empty FIFO", test_id);
			timeouts = timeouts + 1;
		end
	endtask

	task automatic take_verdict();
		int n;
		n = 0;
		@(negedge xgmii_rx_clk);
		test_done = 1'b1;
		// the verdict lands one cycle after test_done rises, a short test shows none
		while (!(status.checker_pass || status.rx_mismatch) && (n < 3)) begin
			@(posedge xgmii_rx_clk);
			n = n + 1;
		end
		@(negedge xgmii_rx_clk);
		check_verdict = 1'b1;
		@(negedge xgmii_rx_clk);
		check_verdict = 1'b0;
	endtask

	initial begin
		int row;
		logic [31:0] r;
		rx_ready      = 1'b0;
		gen_enable    = 1'b0;
		test_done     = 1'b0;
		check_reset   = 1'b0;
		check_verdict = 1'b0;
		for (row = 0; row < num_rows; row++) begin
			test_id      = row + 1;
			frame_target = row_frames[row];
			test_corrupt = row_corrupt[row];
			if (row_delay[row] == 0) begin
				next_random(r);
				delay = int'(r % 32'd12) + 1;
			end else begin
				delay = row_delay[row];
			end
			apply_reset();
			send_frames(row_frames[row]);
			wait_drained();
			take_verdict();
		end
		u_mon.print_counts(timeouts);
		if ((u_mon.errors == 0) && (timeouts == 0)) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#2_000_000;
		$display("the simulation ran past its time limit");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/xgmii_check_monitor.sv */
// testbench monitor, counts transmitted frames, predicts the sink status and reports each test
`default_nettype none

module xgmii_check_monitor #(
	parameter int payload_words = xgmii_pkg::default_payload_words,
	parameter int min_matches   = xgmii_pkg::default_min_matches
) (
	input  wire logic                    xgmii_tx_clk,
	input  wire logic                    xgmii_rx_clk,
	input  wire logic                    rx_ready,
	input  wire xgmii_pkg::xgmii_word_t  xgmii_tx,
	input  wire xgmii_pkg::sink_status_t status,
	input  int                           test_id,
	input  int                           frame_target,
	input  int                           corrupt_count,
	input  wire logic                    check_reset,
	input  wire logic                    check_verdict
);

	timeunit 1ns;
	timeprecision 100ps;

	int frames_seen = 0;
	int full_seen = 0;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// start words on the transmit bus, the generator sends one per frame
	always @(posedge xgmii_tx_clk or negedge rx_ready) begin
		if (!rx_ready) begin
			frames_seen <= 0;
		end else if (xgmii_pkg::is_start(xgmii_tx)) begin
			frames_seen <= frames_seen + 1;
		end
	end

	// the FIFO never fills at the default depth, so no frame is turned away
	always @(posedge xgmii_tx_clk or negedge rx_ready) begin
		if (!rx_ready) begin
			full_seen <= 0;
		end else if (status.fifo_full) begin
			full_seen <= 1;
		end
	end

	task automatic expect_value(input string what, input int got, input int expected);
		if (got != expected) begin
			$display("mismatch at %0t ns: test %0d %s is %0d, expected %0d",
				$time, test_id, what, got, expected);
			test_errors = test_errors + 1;
		end
	endtask

	always @(posedge xgmii_rx_clk) begin
		int exp_match;
		int exp_mis;
		int exp_pass;
		// the status registers settle one cycle after reset is released
		if (check_reset) begin
			test_errors = 0;
			expect_value("match_count after reset", int'(status.match_count), 0);
			expect_value("mismatch_count after reset", int'(status.mismatch_count), 0);
			expect_value("idle_state after reset", int'(status.idle_state), 1);
			expect_value("fifo_empty after reset", int'(status.fifo_empty), 1);
			expect_value("fifo_full after reset", int'(status.fifo_full), 0);
			expect_value("checker_pass after reset", int'(status.checker_pass), 0);
			expect_value("rx_mismatch after reset", int'(status.rx_mismatch), 0);
		end
		if (check_verdict) begin
			// every frame carries start, payload and terminate, each compared once
			exp_match = frame_target * (payload_words + 2) - corrupt_count;
			exp_mis   = corrupt_count;
			exp_pass  = ((exp_match >= min_matches) && (exp_mis == 0)) ? 1 : 0;
			expect_value("frames sent", frames_seen, frame_target);
			expect_value("fifo_full seen", full_seen, 0);
			expect_value("match_count", int'(status.match_count), exp_match);
			expect_value("mismatch_count", int'(status.mismatch_count), exp_mis);
			expect_value("checker_pass", int'(status.checker_pass), exp_pass);
			expect_value("rx_mismatch", int'(status.rx_mismatch), (exp_mis > 0) ? 1 : 0);
			tests_run = tests_run + 1;
			if (test_errors != 0) begin
				tests_failed = tests_failed + 1;
				errors = errors + test_errors;
				$display("test %0d failed with %0d wrong values", test_id, test_errors);
			end else begin
				$display("test %0d ok: %0d frames, %0d matches, %0d mismatches",
					test_id, frames_seen, exp_match, exp_mis);
			end
		end
	end

	task automatic print_counts(input int timeouts);
		$display("tests run %0d, tests failed %0d, wrong values %0d, timeouts %0d",
			tests_run, tests_failed, errors, timeouts);
	endtask

endmodule

`default_nettype wire

/* verilog/xgmii_loopback_top.sv */
// top level of the XGMII loopback checker, joins the frame generator and the sink to the buses
`default_nettype none

module xgmii_loopback_top #(
	parameter int payload_words   = xgmii_pkg::default_payload_words,
	parameter int gap_words       = xgmii_pkg::default_gap_words,
	parameter int fifo_depth_log2 = xgmii_pkg::default_fifo_depth_log2,
	parameter int min_matches     = xgmii_pkg::default_min_matches
) (
	input  wire logic                   xgmii_tx_clk,
	input  wire logic                   xgmii_rx_clk,
	input  wire logic                   rx_ready,
	input  wire logic                   gen_enable,
	input  wire logic                   test_done,
	input  wire xgmii_pkg::xgmii_word_t xgmii_rx,
	output xgmii_pkg::xgmii_word_t      xgmii_tx,
	output xgmii_pkg::sink_status_t     status
);

	xgmii_frame_gen #(
		.payload_words (payload_words),
		.gap_words     (gap_words)
	) u_gen (
		.xgmii_tx_clk (xgmii_tx_clk),
		.rx_ready     (rx_ready),
		.enable       (gen_enable),
		.xgmii_tx     (xgmii_tx)
	);

	// the sink watches the same word that leaves on the transmit bus
	xgmii_sink #(
		.fifo_depth_log2 (fifo_depth_log2),
		.min_matches     (min_matches)
	) u_sink (
		.xgmii_tx_clk (xgmii_tx_clk),
		.xgmii_rx_clk (xgmii_rx_clk),
		.rx_ready     (rx_ready),
		.xgmii_tx_mon (xgmii_tx),
		.xgmii_rx     (xgmii_rx),
		.test_done    (test_done),
		.status       (status)
	);

endmodule

`default_nettype wire

/* verilog/xgmii_sink.sv */
// loopback sink, stores transmitted frames and checks received frames against them for a verdict
`default_nettype none

module xgmii_sink #(
	parameter int fifo_depth_log2 = xgmii_pkg::default_fifo_depth_log2,
	parameter int min_matches     = xgmii_pkg::default_min_matches
) (
	input  wire logic                   xgmii_tx_clk,
	input  wire logic                   xgmii_rx_clk,
	input  wire logic                   rx_ready,
	input  wire xgmii_pkg::xgmii_word_t xgmii_tx_mon,
	input  wire xgmii_pkg::xgmii_word_t xgmii_rx,
	input  wire logic                   test_done,
	output xgmii_pkg::sink_status_t     status
);

	localparam logic st_idle = 1'b0;
	localparam logic st_xmit = 1'b1;

	xgmii_pkg::xgmii_word_t fifo_head;

	logic        fifo_full;
	logic        fifo_empty;
	logic        capture;
	logic        packet_write;
	logic        packet_read;
	logic        rx_state;
	logic        test_done_q;
	logic        checker_pass;
	logic        rx_mismatch;
	logic [31:0] match_count;
	logic [31:0] mismatch_count;

	// the start word itself is written, capture then holds the strobe through terminate
	assign packet_write = capture | (xgmii_pkg::is_start(xgmii_tx_mon) & ~fifo_full);

	always_ff @(posedge xgmii_tx_clk or negedge rx_ready) begin
		if (!rx_ready) begin
			capture <= 1'b0;
		end else if (packet_write && xgmii_pkg::is_terminate(xgmii_tx_mon)) begin
			capture <= 1'b0;
		end else if (xgmii_pkg::is_start(xgmii_tx_mon) && !fifo_full) begin
			capture <= 1'b1;
		end
	end

	// every word from the received start through terminate pops one stored word
	assign packet_read = (rx_state == st_xmit) |
		(xgmii_pkg::is_start(xgmii_rx) & ~fifo_empty);

	always_ff @(posedge xgmii_rx_clk or negedge rx_ready) begin
		if (!rx_ready) begin
			rx_state       <= st_idle;
			test_done_q    <= 1'b0;
			match_count    <= '0;
			mismatch_count <= '0;
			checker_pass   <= 1'b0;
			rx_mismatch    <= 1'b0;
		end else begin
			test_done_q <= test_done;
			if (rx_state == st_idle) begin
				if (xgmii_pkg::is_start(xgmii_rx) && !fifo_empty) begin
					rx_state <= st_xmit;
				end
				// the verdict is only taken between frames
				if (test_done && !test_done_q) begin
					checker_pass <= (match_count >= 32'(min_matches)) && (mismatch_count == '0);
					rx_mismatch  <= (mismatch_count != '0);
				end
			end else if (xgmii_pkg::is_terminate(xgmii_rx)) begin
				rx_state <= st_idle;
			end
			if (packet_read) begin
				if (xgmii_rx.flat == fifo_head.flat) begin
					match_count <= match_count + 32'd1;
				end else begin
					mismatch_count <= mismatch_count + 32'd1;
				end
			end
		end
	end

	assign status = '{
		match_count:    match_count,
		mismatch_count: mismatch_count,
		idle_state:     (rx_state == st_idle),
		checker_pass:   checker_pass,
		rx_mismatch:    rx_mismatch,
		fifo_full:      fifo_full,
		fifo_empty:     fifo_empty
	};

	async_word_fifo #(
		.depth_log2 (fifo_depth_log2)
	) u_fifo (
		.wr_clk  (xgmii_tx_clk),
		.rd_clk  (xgmii_rx_clk),
		.aclr_n  (rx_ready),
		.wr_en   (packet_write),
		.wr_data (xgmii_tx_mon),
		.rd_en   (packet_read),
		.rd_data (fifo_head),
		.full    (fifo_full),
		.empty   (fifo_empty)
	);

	// a frame in progress on rx must have its stored copy already across the FIFO
	a_head_present: assert property (
		@(posedge xgmii_rx_clk) disable iff (!rx_ready) (rx_state == st_xmit) |-> !fifo_empty
	) else $error("received word compared against an empty FIFO");

endmodule

`default_nettype wire

/* verilog/xgmii_frame_gen.sv */
// transmit side frame source, emits start, payload and terminate words with idle gaps on the tx clock
`default_nettype none

module xgmii_frame_gen #(
	parameter int payload_words = xgmii_pkg::default_payload_words,
	parameter int gap_words     = xgmii_pkg::default_gap_words
) (
	input  wire logic             xgmii_tx_clk,
	input  wire logic             rx_ready,
	input  wire logic             enable,
	output xgmii_pkg::xgmii_word_t xgmii_tx
);

	localparam logic [1:0] st_gap     = 2'd0;
	localparam logic [1:0] st_start   = 2'd1;
	localparam logic [1:0] st_payload = 2'd2;
	localparam logic [1:0] st_term    = 2'd3;

	localparam logic [63:0] lfsr_seed = 64'h9e37_79b9_7f4a_7c15;

	localparam logic [71:0] idle_word = {{8{xgmii_pkg::xgmii_idle}}, 8'hff};
	localparam logic [71:0] term_word = {{7{xgmii_pkg::xgmii_idle}}, xgmii_pkg::xgmii_terminate,
		8'hff};
	// start in lane 0, six preamble bytes and the SFD in lane 7
	localparam logic [71:0] start_word = {xgmii_pkg::xgmii_sfd, {6{xgmii_pkg::xgmii_preamble}},
		xgmii_pkg::xgmii_start, 8'h01};

	logic [1:0]  state;
	logic [15:0] gap_cnt;
	logic [15:0] word_cnt;
	logic [63:0] lfsr;

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	// the output word is registered, state says what goes out on the next edge
	always_ff @(posedge xgmii_tx_clk or negedge rx_ready) begin
		if (!rx_ready) begin
			state         <= st_gap;
			gap_cnt       <= '0;
			word_cnt      <= '0;
			lfsr          <= lfsr_seed;
			xgmii_tx.flat <= idle_word;
		end else begin
			case (state)
				st_gap: begin
					xgmii_tx.flat <= idle_word;
					if (gap_cnt < 16'(gap_words)) begin
						gap_cnt <= gap_cnt + 16'd1;
					end
					// enable only matters once the full gap has gone out
					if ((gap_cnt + 16'd1 >= 16'(gap_words)) && enable) begin
						state <= st_start;
					end
				end
				st_start: begin
					xgmii_tx.flat <= start_word;
					word_cnt      <= '0;
					state         <= (payload_words == 0) ? st_term : st_payload;
				end
				st_payload: begin
					xgmii_tx.lanes.d <= lfsr;
					xgmii_tx.lanes.c <= 8'h00;
					lfsr             <= xorshift64(lfsr);
					word_cnt         <= word_cnt + 16'd1;
					if (word_cnt == 16'(payload_words - 1)) begin
						state <= st_term;
					end
				end
				default: begin
					xgmii_tx.flat <= term_word;
					gap_cnt       <= '0;
					state         <= st_gap;
				end
			endcase
		end
	end

	// the terminate word closes the frame right after the last payload word
	a_frame_length: assert property (
		@(posedge xgmii_tx_clk) disable iff (!rx_ready)
		xgmii_pkg::is_start(xgmii_tx) |-> ##(payload_words + 1) xgmii_pkg::is_terminate(xgmii_tx)
	) else $error("terminate word not %0d words after start", payload_words + 1);

endmodule

`default_nettype wire

/* verilog/async_word_fifo.sv */
// dual clock show-ahead FIFO of XGMII words with Gray pointers, used by the sink to cross tx to rx
`default_nettype none

module async_word_fifo #(
	parameter int depth_log2 = xgmii_pkg::default_fifo_depth_log2
) (
	input  wire logic                   wr_clk,
	input  wire logic                   rd_clk,
	input  wire logic                   aclr_n,
	input  wire logic                   wr_en,
	input  wire xgmii_pkg::xgmii_word_t wr_data,
	input  wire logic                   rd_en,
	output xgmii_pkg::xgmii_word_t      rd_data,
	output logic                        full,
	output logic                        empty
);

	localparam int ptr_w = depth_log2 + 1;

	logic [71:0] mem [2**depth_log2];

	logic [ptr_w-1:0] wr_bin;
	logic [ptr_w-1:0] wr_gray;
	logic [ptr_w-1:0] wr_bin_next;
	logic [ptr_w-1:0] wr_gray_next;
	logic [ptr_w-1:0] rd_bin;
	logic [ptr_w-1:0] rd_gray;
	logic [ptr_w-1:0] rd_bin_next;
	logic [ptr_w-1:0] rd_gray_next;

	// two stage synchronizers, the first stage of each may go metastable
	logic [ptr_w-1:0] rd_gray_s1;
	logic [ptr_w-1:0] rd_gray_s2;
	logic [ptr_w-1:0] wr_gray_s1;
	logic [ptr_w-1:0] wr_gray_s2;

	logic wr_inc;
	logic rd_inc;

	// the flags guard the pointers so no word is ever dropped or read twice
	assign wr_inc       = wr_en & ~full;
	assign rd_inc       = rd_en & ~empty;
	assign wr_bin_next  = wr_bin + ptr_w'(wr_inc);
	assign rd_bin_next  = rd_bin + ptr_w'(rd_inc);
	assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;
	assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

	always_ff @(posedge wr_clk) begin
		if (wr_inc) begin
			mem[wr_bin[depth_log2-1:0]] <= wr_data.flat;
		end
	end

	// head of the queue is visible before rd_en
	assign rd_data.flat = mem[rd_bin[depth_log2-1:0]];

	always_ff @(posedge wr_clk or negedge aclr_n) begin
		if (!aclr_n) begin
			wr_bin     <= '0;
			wr_gray    <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
			full       <= 1'b0;
		end else begin
			wr_bin     <= wr_bin_next;
			wr_gray    <= wr_gray_next;
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
			// full when the write pointer has lapped the read pointer once
			full <= (wr_gray_next == {~rd_gray_s2[ptr_w-1:ptr_w-2], rd_gray_s2[ptr_w-3:0]});
		end
	end

	always_ff @(posedge rd_clk or negedge aclr_n) begin
		if (!aclr_n) begin
			rd_bin     <= '0;
			rd_gray    <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
			empty      <= 1'b1;
		end else begin
			rd_bin     <= rd_bin_next;
			rd_gray    <= rd_gray_next;
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			empty      <= (rd_gray_next == wr_gray_s2);
		end
	end

	a_no_write_full: assert property (
		@(posedge wr_clk) disable iff (!aclr_n) wr_en |-> !full
	) else $error("FIFO written while full");

	a_no_read_empty: assert property (
		@(posedge rd_clk) disable iff (!aclr_n) rd_en |-> !empty
	) else $error("FIFO read while empty");

endmodule

`default_nettype wire

/* verilog/xgmii_pkg.sv */
// shared XGMII characters, word and status types and default sizes for the loopback checker
`default_nettype none

package xgmii_pkg;

	// control characters, sent with their lane control bit set
	localparam logic [7:0] xgmii_start     = 8'hfb;
	localparam logic [7:0] xgmii_terminate = 8'hfd;
	localparam logic [7:0] xgmii_idle      = 8'h07;

	// data characters that fill the rest of the start word
	localparam logic [7:0] xgmii_preamble  = 8'h55;
	localparam logic [7:0] xgmii_sfd       = 8'hd5;

	// defaults for the top level parameters
	localparam int default_payload_words   = 8;
	localparam int default_gap_words       = 4;
	localparam int default_fifo_depth_log2 = 6;
	localparam int default_min_matches     = 100;

	// lane 0 is d[7:0] and its control bit is c[0]
	typedef struct packed {
		logic [63:0] d;
		logic [7:0]  c;
	} xgmii_lanes_t;

	// the FIFO moves the flat view, the framing logic looks at the lanes
	typedef union packed {
		logic [71:0]  flat;
		xgmii_lanes_t lanes;
	} xgmii_word_t;

	typedef struct packed {
		logic [31:0] match_count;
		logic [31:0] mismatch_count;
		logic        idle_state;
		logic        checker_pass;
		logic        rx_mismatch;
		logic        fifo_full;
		logic        fifo_empty;
	} sink_status_t;

	// start is only recognised in lane 0, there is no lane 4 alignment
	function automatic logic is_start(xgmii_word_t w);
		return w.lanes.c[0] && (w.lanes.d[7:0] == xgmii_start);
	endfunction

	function automatic logic is_terminate(xgmii_word_t w);
		return w.lanes.c[0] && (w.lanes.d[7:0] == xgmii_terminate);
	endfunction

endpackage

`default_nettype wire
